//--- flist.f
source/video_pkg.sv
source/wb_regs.sv
source/video_timing.sv
source/frame_fetch.sv
source/video_out.sv
source/video_reader_top.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_top
FLIST    = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	import video_pkg::*;

	localparam int H_VIS     = 8;
	localparam int H_FP      = 2;
	localparam int H_SY      = 2;
	localparam int H_BP      = 2;
	localparam int V_VIS     = 4;
	localparam int V_FP      = 1;
	localparam int V_SY      = 1;
	localparam int V_BP      = 1;
	localparam int FRAME_LEN = (H_VIS + H_FP + H_SY + H_BP) * (V_VIS + V_FP + V_SY + V_BP);
	localparam int N_TESTS   = 10;
	localparam int LIMIT     = 256 * 4 + 50 + N_TESTS * 6 * FRAME_LEN + 200;

	localparam logic [31:0] VDMA = 32'h4001_0000;
	localparam logic [31:0] GPIO = 32'h4002_1000;
	localparam logic [31:0] FBUF = 32'h4003_0000;

	typedef struct packed {
		int                nwr;
		logic [1:0][31:0]  wadr;
		logic [1:0][31:0]  wdat;
		logic [31:0]       radr;
		logic [31:0]       rexp;
		int                rkind;
		int                delay;
		int                mode;
		int                skip;
		int                frames;
		logic [7:0]        ao;
		logic [7:0]        so;
		logic [7:0]        an;
		logic [7:0]        sn;
		logic [3:0]        led;
	} entry_t;

	logic              clk;
	logic              arst_n;
	wb_req_t           req;
	wb_rsp_t           rsp;
	logic [3:0]        led;
	video_t            video;
	pixel_t            fb_copy [256];
	entry_t            tbl [N_TESTS];
	string             tname [N_TESTS];
	logic [31:0]       rng;
	int                cycles;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic entry_t mk(input int nwr, input logic [31:0] wa0, input logic [31:0] wd0,
		input logic [31:0] wa1, input logic [31:0] wd1, input logic [31:0] ra,
		input logic [31:0] rexp, input int rkind, input int delay, input int mode,
		input int skip, input int frames, input logic [7:0] ao, input logic [7:0] so,
		input logic [7:0] an, input logic [7:0] sn, input logic [3:0] led_exp);
		entry_t e;
		e = '{nwr: nwr, wadr: {wa1, wa0}, wdat: {wd1, wd0}, radr: ra, rexp: rexp,
			rkind: rkind, delay: delay, mode: mode, skip: skip, frames: frames,
			ao: ao, so: so, an: an, sn: sn, led: led_exp};
		return e;
	endfunction

	video_reader_top #(
		.H_VISIBLE (H_VIS), .H_FRONT (H_FP), .H_SYNC (H_SY), .H_BACK (H_BP),
		.V_VISIBLE (V_VIS), .V_FRONT (V_FP), .V_SYNC (V_SY), .V_BACK (V_BP)
	) i_dut (
		.wb_clk_o (clk),
		.arst_n_i (arst_n),
		.wb_req_i (req),
		.wb_rsp_o (rsp),
		.led_o    (led),
		.video_o  (video)
	);

	tb_checker #(
		.FRAME_LEN (FRAME_LEN)
	) i_checker (
		.clk_i     (clk),
		.arst_n_i  (arst_n),
		.wb_rsp_i  (rsp),
		.led_i     (led),
		.video_i   (video),
		.fb_copy_i (fb_copy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Hard stop if anything hangs
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= LIMIT) begin
				$display("Run stopped after %0d cycles without finishing", cycles);
				$display("Done: errors found");
				$finish;
			end
		end
	end

	// One strobe, held until the ack, dropped on the next edge
	task automatic bus_access(input string name, input logic [31:0] badr,
		input logic [31:0] dat, input logic we);
		int   waited;
		logic acked;
		@(posedge clk);
		req <= '{adr: badr[31:2], dat: dat, we: we, sel: 4'hf, stb: 1'b1};
		waited = 0;
		acked  = 1'b0;
		while (!acked && waited < 20) begin
			@(negedge clk);
			acked = rsp.ack;
			waited++;
		end
		@(posedge clk);
		req.stb <= 1'b0;
		if (!acked)
			i_checker.report_error(name, "bus access got no acknowledge");
	endtask

	initial begin
		req    = '0;
		arst_n = 1'b0;
		rng    = 32'hbe65b924;
		foreach (fb_copy[i])
			fb_copy[i] = '0;

		tname[0] = "reset_state";
		tbl[0] = mk(0, 0, 0, 0, 0, GPIO, 32'h5, 0, 0, 1, 0, 1, 0, 0, 0, 0, 4'h5);
		tname[1] = "led_write";
		tbl[1] = mk(1, GPIO, 32'ha, 0, 0, GPIO, 32'ha, 0, 0, 0, 0, 0, 0, 0, 0, 0, 4'ha);
		tname[2] = "unmapped_read";
		tbl[2] = mk(0, 0, 0, 0, 0, 32'h5000_0000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 4'ha);
		tname[3] = "addr_reg";
		tbl[3] = mk(1, VDMA + 8, 32'h10, 0, 0, VDMA + 8, 32'h10, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 4'ha);
		tname[4] = "stride_reg";
		tbl[4] = mk(1, VDMA + 12, 32'h0c, 0, 0, VDMA + 12, 32'h0c, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 4'ha);
		tname[5] = "fbuf_read";
		tbl[5] = mk(0, 0, 0, 0, 0, FBUF + 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 4'ha);
		tname[6] = "frame_read";
		tbl[6] = mk(1, VDMA, 32'h1, 0, 0, VDMA, 32'h1, 0, 0, 2, 1, 2,
			8'h10, 8'h0c, 8'h10, 8'h0c, 4'ha);
		// New pair lands in the middle of the watched frames
		tname[7] = "param_latch";
		tbl[7] = mk(2, VDMA + 8, 32'h80, VDMA + 12, 32'h21, VDMA + 12, 32'h21, 0, 150, 2, 0, 3,
			8'h10, 8'h0c, 8'h80, 8'h21, 4'ha);
		tname[8] = "frame_stop";
		tbl[8] = mk(1, VDMA, 32'h0, 0, 0, VDMA + 4, 0, 1, 0, 1, 1, 1, 0, 0, 0, 0, 4'ha);
		tname[9] = "status_hold";
		tbl[9] = mk(0, 0, 0, 0, 0, VDMA + 4, 0, 2, FRAME_LEN + 10, 0, 0, 0,
			0, 0, 0, 0, 4'ha);

		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		// Fill the frame memory and keep a copy
		for (int i = 0; i < 256; i++) begin
			rng = xorshift(rng);
			fb_copy[i] = rng[23:0];
			bus_access("fbuf_fill", FBUF + 32'(i * 4), {8'h0, rng[23:0]}, 1'b1);
		end

		for (int t = 0; t < N_TESTS; t++) begin
			fork
				begin
					repeat (tbl[t].delay) @(posedge clk);
					for (int w = 0; w < tbl[t].nwr; w++)
						bus_access(tname[t], tbl[t].wadr[w], tbl[t].wdat[w], 1'b1);
					bus_access(tname[t], tbl[t].radr, 32'h0, 1'b0);
					i_checker.check_read(tname[t], tbl[t].rkind, tbl[t].rexp);
					i_checker.check_led(tname[t], tbl[t].led);
				end
				begin
					if (tbl[t].mode != 0)
						i_checker.watch(tname[t], tbl[t].mode, tbl[t].skip, tbl[t].frames,
							tbl[t].ao, tbl[t].so, tbl[t].an, tbl[t].sn);
				end
			join
			i_checker.end_test(tname[t]);
		end

		i_checker.summary();
		if (i_checker.errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- tests/tb_checker.sv
module tb_checker #(
	parameter int FRAME_LEN = 98
) (
	input logic                            clk_i,
	input logic                            arst_n_i,
	input video_pkg::wb_rsp_t              wb_rsp_i,
	input logic [video_pkg::LED_WIDTH-1:0] led_i,
	input video_pkg::video_t               video_i,
	input video_pkg::pixel_t               fb_copy_i [256]
);
	timeunit 1ns;
	timeprecision 1ps;

	import video_pkg::*;

	int         errors      = 0;
	int         test_errors = 0;
	int         tests       = 0;
	int         failed      = 0;
	logic [31:0] rd_last    = '0;
	logic [31:0] rd_saved   = '0;
	string      cur_name    = "";
	int         mode        = 0;
	int         skip_left   = 0;
	int         frames_left = 0;
	logic       armed       = 1'b0;
	logic       ok_old;
	logic       ok_new;
	logic [7:0] a_old;
	logic [7:0] s_old;
	logic [7:0] a_new;
	logic [7:0] s_new;
	int         px;
	int         py;
	logic       line_de;
	logic       prev_hs;
	logic       prev_vs;

	function automatic void note_error();
		errors++;
		test_errors++;
	endfunction

	// Word the pipeline must show at (px, py) for start a and stride s
	function automatic pixel_t mem_pixel(input logic [7:0] a, input logic [7:0] s);
		logic [7:0] idx;
		idx = 8'(int'(a) + py * int'(s) + px);
		return fb_copy_i[idx];
	endfunction

	function automatic void check_pixel();
		pixel_t exp_old;
		pixel_t exp_new;
		if (!video_i.de) begin
			if (video_i.data != '0) begin
				note_error();
				if (test_errors < 6)
					$display("FAIL %s blank: expected %h, actual %h", cur_name, 24'h0,
						video_i.data);
			end
		end else if (mode == 1) begin
			exp_new = COLOR_BARS[px % 8];
			if (video_i.data != exp_new) begin
				note_error();
				if (test_errors < 6)
					$display("FAIL %s bar (%0d,%0d): expected %h, actual %h", cur_name, px,
						py, exp_new, video_i.data);
			end
		end else begin
			exp_old = mem_pixel(a_old, s_old);
			exp_new = mem_pixel(a_new, s_new);
			if (video_i.data != exp_old)
				ok_old = 1'b0;
			if (video_i.data != exp_new)
				ok_new = 1'b0;
			if (video_i.data != exp_old && video_i.data != exp_new) begin
				note_error();
				if (test_errors < 6)
					$display("FAIL %s pixel (%0d,%0d): expected %h, actual %h", cur_name, px,
						py, exp_new, video_i.data);
			end
		end
	endfunction

	// Sync pulses lie outside the visible area
	function automatic void check_sync();
		if (video_i.de && (video_i.hsync || video_i.vsync)) begin
			note_error();
			if (test_errors < 6)
				$display("%s: sync pulse overlaps the visible area at (%0d,%0d)", cur_name,
					px, py);
		end
	endfunction

	// Start of vsync closes one frame
	function automatic void frame_tick();
		if (skip_left > 0) begin
			skip_left--;
			if (skip_left == 0) begin
				armed  = 1'b1;
				ok_old = 1'b1;
				ok_new = 1'b1;
			end
		end else if (armed) begin
			if (mode == 2 && !ok_old && !ok_new) begin
				note_error();
				$display("%s: a frame mixed the old and the new address and stride", cur_name);
			end
			ok_old = 1'b1;
			ok_new = 1'b1;
			frames_left--;
			if (frames_left == 0)
				armed = 1'b0;
		end
	endfunction

	// ------------------------------------------------------------------------
	// Video and bus monitors
	// ------------------------------------------------------------------------

	always @(negedge clk_i) begin
		if (!arst_n_i) begin
			px      = 0;
			py      = 0;
			line_de = 1'b0;
			prev_hs = 1'b0;
			prev_vs = 1'b0;
		end else begin
			if (armed) begin
				check_pixel();
				check_sync();
			end
			if (video_i.de) begin
				px++;
				line_de = 1'b1;
			end
			// Rising hsync ends a line
			if (video_i.hsync && !prev_hs) begin
				if (line_de)
					py++;
				px      = 0;
				line_de = 1'b0;
			end
			if (video_i.vsync)
				py = 0;
			if (video_i.vsync && !prev_vs)
				frame_tick();
			prev_hs = video_i.hsync;
			prev_vs = video_i.vsync;
		end
	end

	always @(negedge clk_i) begin
		if (wb_rsp_i.ack)
			rd_last = wb_rsp_i.dat;
	end

	// ------------------------------------------------------------------------
	// Calls from the test sequence
	// ------------------------------------------------------------------------

	task automatic watch(input string name, input int md, input int skip, input int frames,
		input logic [7:0] ao, input logic [7:0] so, input logic [7:0] an, input logic [7:0] sn);
		int waited;
		int limit;
		cur_name    = name;
		a_old       = ao;
		s_old       = so;
		a_new       = an;
		s_new       = sn;
		mode        = md;
		frames_left = frames;
		skip_left   = skip + 1;
		limit       = (skip + frames + 2) * FRAME_LEN;
		waited      = 0;
		while ((skip_left != 0 || frames_left != 0) && waited < limit) begin
			@(posedge clk_i);
			waited++;
		end
		if (skip_left != 0 || frames_left != 0) begin
			note_error();
			$display("%s: expected video frames did not arrive within %0d cycles", name, limit);
		end
		armed       = 1'b0;
		mode        = 0;
		skip_left   = 0;
		frames_left = 0;
	endtask

	// Kind 0 exact, 1 nonzero, 2 same as the previous read
	task automatic check_read(input string name, input int kind, input logic [31:0] exp);
		logic [31:0] want;
		want = (kind == 2) ? rd_saved : exp;
		if (kind == 1) begin
			if (rd_last == '0) begin
				note_error();
				$display("FAIL %s read: expected nonzero, actual %h", name, rd_last);
			end
		end else if (rd_last != want) begin
			note_error();
			$display("FAIL %s read: expected %h, actual %h", name, want, rd_last);
		end
		rd_saved = rd_last;
	endtask

	task automatic check_led(input string name, input logic [LED_WIDTH-1:0] exp);
		if (led_i !== exp) begin
			note_error();
			$display("FAIL %s led: expected %h, actual %h", name, exp, led_i);
		end
	endtask

	task automatic report_error(input string name, input string what);
		note_error();
		$display("%s: %s", name, what);
	endtask

	task automatic end_test(input string name);
		tests++;
		if (test_errors != 0) begin
			failed++;
			$display("%s: FAIL (%0d errors)", name, test_errors);
		end else begin
			$display("%s: PASS", name);
		end
		test_errors = 0;
	endtask

	task automatic summary();
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
	endtask

endmodule

//--- source/video_reader_top.sv
module video_reader_top #(
	parameter int H_VISIBLE = 8,
	parameter int H_FRONT   = 2,
	parameter int H_SYNC    = 2,
	parameter int H_BACK    = 2,
	parameter int V_VISIBLE = 4,
	parameter int V_FRONT   = 1,
	parameter int V_SYNC    = 1,
	parameter int V_BACK    = 1
) (
	input  logic                            wb_clk_o,
	input  logic                            arst_n_i,
	input  video_pkg::wb_req_t              wb_req_i,
	output video_pkg::wb_rsp_t              wb_rsp_o,
	output logic [video_pkg::LED_WIDTH-1:0] led_o,
	output video_pkg::video_t               video_o
);
	import video_pkg::*;

	vdma_cfg_t cfg;
	logic      frame_started;
	logic      fb_we;
	fb_adr_t   fb_adr;
	pixel_t    fb_dat;
	timing_t   tgen_timing;
	timing_t   fetch_timing;
	pixel_t    fetch_pixel;
	logic      mem_valid;

	// ------------------------------------------------------------------------
	// Host registers
	// ------------------------------------------------------------------------

	wb_regs
		i_wb_regs (
			.wb_clk_o        (wb_clk_o),
			.arst_n_i        (arst_n_i),
			.wb_req_i        (wb_req_i),
			.wb_rsp_o        (wb_rsp_o),
			.led_o           (led_o),
			.cfg_o           (cfg),
			.frame_started_i (frame_started),
			.fb_we_o         (fb_we),
			.fb_adr_o        (fb_adr),
			.fb_dat_o        (fb_dat)
		);

	// ------------------------------------------------------------------------
	// Video pipeline
	// ------------------------------------------------------------------------

	video_timing #(
		.H_VISIBLE (H_VISIBLE),
		.H_FRONT   (H_FRONT),
		.H_SYNC    (H_SYNC),
		.H_BACK    (H_BACK),
		.V_VISIBLE (V_VISIBLE),
		.V_FRONT   (V_FRONT),
		.V_SYNC    (V_SYNC),
		.V_BACK    (V_BACK)
	) i_video_timing (
		.wb_clk_o (wb_clk_o),
		.arst_n_i (arst_n_i),
		.timing_o (tgen_timing)
	);

	frame_fetch #(
		.H_VISIBLE (H_VISIBLE),
		.V_VISIBLE (V_VISIBLE)
	) i_frame_fetch (
		.wb_clk_o        (wb_clk_o),
		.arst_n_i        (arst_n_i),
		.timing_i        (tgen_timing),
		.cfg_i           (cfg),
		.fb_we_i         (fb_we),
		.fb_adr_i        (fb_adr),
		.fb_dat_i        (fb_dat),
		.frame_started_o (frame_started),
		.timing_o        (fetch_timing),
		.pixel_o         (fetch_pixel),
		.mem_valid_o     (mem_valid)
	);

	video_out #(
		.H_VISIBLE (H_VISIBLE)
	) i_video_out (
		.wb_clk_o    (wb_clk_o),
		.arst_n_i    (arst_n_i),
		.timing_i    (fetch_timing),
		.pixel_i     (fetch_pixel),
		.mem_valid_i (mem_valid),
		.video_o     (video_o)
	);

endmodule

//--- source/video_out.sv
module video_out #(
	parameter int H_VISIBLE = 8
) (
	input  logic               wb_clk_o,
	input  logic               arst_n_i,
	input  video_pkg::timing_t timing_i,
	input  video_pkg::pixel_t  pixel_i,
	input  logic               mem_valid_i,
	output video_pkg::video_t  video_o
);
	import video_pkg::*;

	pixel_t pix_sel;
	logic   bar_on;
	video_t video_q;

	// Bars only inside the visible width
	assign bar_on = timing_i.de && (timing_i.x < 8'(H_VISIBLE));

	// Memory pixel, else colour bar, else blank
	always_comb begin
		if (mem_valid_i) begin
			pix_sel = pixel_i;
		end else if (bar_on) begin
			pix_sel = COLOR_BARS[timing_i.x[2:0]];
		end else begin
			pix_sel = '0;
		end
	end

	always_ff @(posedge wb_clk_o or negedge arst_n_i) begin
		if (!arst_n_i) begin
			video_q <= '0;
		end else begin
			video_q <= '{
				vsync: timing_i.vsync,
				hsync: timing_i.hsync,
				de:    timing_i.de,
				data:  pix_sel
			};
		end
	end

	assign video_o = video_q;

endmodule

//--- source/frame_fetch.sv
module frame_fetch #(
	parameter int H_VISIBLE = 8,
	parameter int V_VISIBLE = 4
) (
	input  logic                 wb_clk_o,
	input  logic                 arst_n_i,
	input  video_pkg::timing_t   timing_i,
	input  video_pkg::vdma_cfg_t cfg_i,
	input  logic                 fb_we_i,
	input  video_pkg::fb_adr_t   fb_adr_i,
	input  video_pkg::pixel_t    fb_dat_i,
	output logic                 frame_started_o,
	output video_pkg::timing_t   timing_o,
	output video_pkg::pixel_t    pixel_o,
	output logic                 mem_valid_o
);
	import video_pkg::*;

	pixel_t    mem [256];
	vdma_cfg_t cfg_q;
	vdma_cfg_t cfg_cur;
	fb_adr_t   line_base_q;
	fb_adr_t   base_cur;
	fb_adr_t   rd_adr;
	logic      line_end;
	logic      last_line;
	timing_t   timing_q;
	pixel_t    pixel_q;
	logic      valid_q;
	logic      started_q;

	// ------------------------------------------------------------------------
	// Address generation
	// ------------------------------------------------------------------------

	// First pixel of a frame already uses the freshly latched values
	assign cfg_cur  = timing_i.frame_start ? cfg_i : cfg_q;
	assign base_cur = timing_i.frame_start ? cfg_i.addr : line_base_q;

	// Wraps modulo 256
	assign rd_adr = base_cur + timing_i.x;

	assign line_end  = timing_i.de && (timing_i.x == 8'(H_VISIBLE - 1));
	assign last_line = timing_i.y == 8'(V_VISIBLE - 1);

	always_ff @(posedge wb_clk_o or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cfg_q       <= '0;
			line_base_q <= '0;
			timing_q    <= '0;
			valid_q     <= 1'b0;
			started_q   <= 1'b0;
		end else begin
			if (timing_i.frame_start) begin
				cfg_q       <= cfg_i;
				line_base_q <= cfg_i.addr;
			end
			// Step to the next line, base holds after the last one
			if (line_end && !last_line) begin
				line_base_q <= base_cur + cfg_cur.stride;
			end
			timing_q  <= timing_i;
			valid_q   <= timing_i.de && cfg_cur.enable;
			started_q <= timing_i.frame_start;
		end
	end

	// ------------------------------------------------------------------------
	// Frame memory
	// ------------------------------------------------------------------------

	always_ff @(posedge wb_clk_o) begin
		if (fb_we_i) begin
			mem[fb_adr_i] <= fb_dat_i;
		end
		pixel_q <= mem[rd_adr];
	end

	assign frame_started_o = started_q;
	assign timing_o        = timing_q;
	assign pixel_o         = pixel_q;
	assign mem_valid_o     = valid_q;

endmodule

//--- source/video_timing.sv
module video_timing #(
	parameter int H_VISIBLE = 8,
	parameter int H_FRONT   = 2,
	parameter int H_SYNC    = 2,
	parameter int H_BACK    = 2,
	parameter int V_VISIBLE = 4,
	parameter int V_FRONT   = 1,
	parameter int V_SYNC    = 1,
	parameter int V_BACK    = 1
) (
	input  logic               wb_clk_o,
	input  logic               arst_n_i,
	output video_pkg::timing_t timing_o
);
	import video_pkg::*;

	localparam logic [7:0] V_LAST       = 8'(V_VISIBLE + V_FRONT + V_SYNC + V_BACK - 1);
	localparam logic [7:0] V_SYNC_START = 8'(V_VISIBLE + V_FRONT);
	localparam logic [7:0] V_SYNC_END   = 8'(V_VISIBLE + V_FRONT + V_SYNC);

	h_phase_e   phase_q;
	h_phase_e   phase_next;
	logic [7:0] h_len;
	logic [7:0] h_cnt_q;
	logic [7:0] v_cnt_q;
	logic       h_last;
	logic       line_end;

	// Length and successor of each horizontal phase
	always_comb begin
		case (phase_q)
			ACTIVE: begin
				h_len      = 8'(H_VISIBLE);
				phase_next = FRONT;
			end
			FRONT: begin
				h_len      = 8'(H_FRONT);
				phase_next = SYNC;
			end
			SYNC: begin
				h_len      = 8'(H_SYNC);
				phase_next = BACK;
			end
			default: begin
				h_len      = 8'(H_BACK);
				phase_next = ACTIVE;
			end
		endcase
	end

	assign h_last   = h_cnt_q == h_len - 8'd1;
	assign line_end = h_last && (phase_q == BACK);

	always_ff @(posedge wb_clk_o or negedge arst_n_i) begin
		if (!arst_n_i) begin
			phase_q <= ACTIVE;
			h_cnt_q <= '0;
			v_cnt_q <= '0;
		end else begin
			if (h_last) begin
				phase_q <= phase_next;
				h_cnt_q <= '0;
			end else begin
				h_cnt_q <= h_cnt_q + 8'd1;
			end
			if (line_end) begin
				v_cnt_q <= (v_cnt_q == V_LAST) ? 8'd0 : v_cnt_q + 8'd1;
			end
		end
	end

	always_comb begin
		timing_o.vsync       = (v_cnt_q >= V_SYNC_START) && (v_cnt_q < V_SYNC_END);
		timing_o.hsync       = phase_q == SYNC;
		timing_o.de          = (phase_q == ACTIVE) && (v_cnt_q < 8'(V_VISIBLE));
		timing_o.frame_start = (phase_q == ACTIVE) && (h_cnt_q == 8'd0) && (v_cnt_q == 8'd0);
		timing_o.x           = h_cnt_q;
		timing_o.y           = v_cnt_q;
	end

endmodule

//--- source/wb_regs.sv
module wb_regs (
	input  logic                            wb_clk_o,
	input  logic                            arst_n_i,
	input  video_pkg::wb_req_t              wb_req_i,
	output video_pkg::wb_rsp_t              wb_rsp_o,
	output logic [video_pkg::LED_WIDTH-1:0] led_o,
	output video_pkg::vdma_cfg_t            cfg_o,
	input  logic                            frame_started_i,
	output logic                            fb_we_o,
	output video_pkg::fb_adr_t              fb_adr_o,
	output video_pkg::pixel_t               fb_dat_o
);
	import video_pkg::*;

	region_e              region;
	vdma_reg_e            reg_sel;
	logic                 access;
	logic                 ack_q;
	wb_dat_t              rd_dat;
	wb_dat_t              rd_dat_q;
	logic [LED_WIDTH-1:0] led_q;
	vdma_cfg_t            cfg_q;
	logic [15:0]          frame_cnt_q;

	// ------------------------------------------------------------------------
	// Address decoder
	// ------------------------------------------------------------------------

	always_comb begin
		case (wb_req_i.adr[29:10])
			PAGE_VDMA: region = REGION_VDMA;
			PAGE_GPIO: region = REGION_GPIO;
			PAGE_FBUF: region = REGION_FBUF;
			default:   region = REGION_NONE;
		endcase
	end

	assign reg_sel = vdma_reg_e'(wb_req_i.adr[1:0]);

	// First cycle of a strobe, the ack goes out on the next edge
	assign access = wb_req_i.stb & ~ack_q;

	always_ff @(posedge wb_clk_o or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// ------------------------------------------------------------------------
	// Read data
	// ------------------------------------------------------------------------

	always_comb begin
		rd_dat = '0;
		case (region)
			REGION_VDMA: begin
				case (reg_sel)
					REG_CTRL:   rd_dat = {31'd0, cfg_q.enable};
					REG_STATUS: rd_dat = {16'd0, frame_cnt_q};
					REG_ADDR:   rd_dat = {24'd0, cfg_q.addr};
					REG_STRIDE: rd_dat = {24'd0, cfg_q.stride};
					default:    rd_dat = '0;
				endcase
			end
			REGION_GPIO: rd_dat = {{(32 - LED_WIDTH){1'b0}}, led_q};
			// Frame window is write only
			default:     rd_dat = '0;
		endcase
	end

	always_ff @(posedge wb_clk_o) begin
		if (access) begin
			rd_dat_q <= rd_dat;
		end
	end

	assign wb_rsp_o = '{dat: rd_dat_q, ack: ack_q};

	// ------------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------------

	always_ff @(posedge wb_clk_o or negedge arst_n_i) begin
		if (!arst_n_i) begin
			led_q       <= LED_INIT;
			cfg_q       <= '0;
			frame_cnt_q <= '0;
		end else begin
			if (access && wb_req_i.we) begin
				case (region)
					REGION_GPIO: led_q <= wb_req_i.dat[LED_WIDTH-1:0];
					REGION_VDMA: begin
						case (reg_sel)
							REG_CTRL:   cfg_q.enable <= wb_req_i.dat[0];
							REG_ADDR:   cfg_q.addr   <= wb_req_i.dat[7:0];
							REG_STRIDE: cfg_q.stride <= wb_req_i.dat[7:0];
							default:    ;
						endcase
					end
					default: ;
				endcase
			end
			// Frames started while reading is on
			if (frame_started_i && cfg_q.enable) begin
				frame_cnt_q <= frame_cnt_q + 16'd1;
			end
		end
	end

	assign led_o = led_q;
	assign cfg_o = cfg_q;

	// Frame memory port, word index from byte address bits 9 to 2
	assign fb_we_o  = access & wb_req_i.we & (region == REGION_FBUF);
	assign fb_adr_o = wb_req_i.adr[7:0];
	assign fb_dat_o = wb_req_i.dat[23:0];

endmodule

//--- source/video_pkg.sv
package video_pkg;

	// ------------------------------------------------------------------------
	// Host bus
	// ------------------------------------------------------------------------

	// Word address, byte address bits 31 to 2
	typedef logic [29:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	typedef struct packed {
		wb_adr_t    adr;
		wb_dat_t    dat;
		logic       we;
		logic [3:0] sel;
		logic       stb;
	} wb_req_t;

	typedef struct packed {
		wb_dat_t dat;
		logic    ack;
	} wb_rsp_t;

	typedef enum logic [1:0] {
		REGION_VDMA,
		REGION_GPIO,
		REGION_FBUF,
		REGION_NONE
	} region_e;

	// Page select, byte address bits 31 to 12
	localparam logic [19:0] PAGE_VDMA = 20'h4001_0;
	localparam logic [19:0] PAGE_GPIO = 20'h4002_1;
	localparam logic [19:0] PAGE_FBUF = 20'h4003_0;

	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_STATUS = 2'd1,
		REG_ADDR   = 2'd2,
		REG_STRIDE = 2'd3
	} vdma_reg_e;

	localparam int                   LED_WIDTH = 4;
	localparam logic [LED_WIDTH-1:0] LED_INIT  = 4'b0101;

	// ------------------------------------------------------------------------
	// Video path
	// ------------------------------------------------------------------------

	typedef logic [23:0] pixel_t;
	typedef logic [7:0]  fb_adr_t;

	typedef struct packed {
		logic    enable;
		fb_adr_t addr;
		fb_adr_t stride;
	} vdma_cfg_t;

	typedef enum logic [1:0] {
		ACTIVE,
		FRONT,
		SYNC,
		BACK
	} h_phase_e;

	typedef struct packed {
		logic       vsync;
		logic       hsync;
		logic       de;
		logic       frame_start;
		logic [7:0] x;
		logic [7:0] y;
	} timing_t;

	typedef struct packed {
		logic   vsync;
		logic   hsync;
		logic   de;
		pixel_t data;
	} video_t;

	// White, yellow, cyan, green, magenta, red, blue, black
	localparam pixel_t COLOR_BARS [8] = '{
		24'hff_ff_ff, 24'hff_ff_00, 24'h00_ff_ff, 24'h00_ff_00,
		24'hff_00_ff, 24'hff_00_00, 24'h00_00_ff, 24'h00_00_00
	};

endpackage
